// ==== files.f ====
lc3b_types.sv
lc3b_ctrl_pkg.sv
mem_req_if.sv
control_rom.sv
regfile.sv
alu.sv
branch_unit.sv
dcache_ctrlr.sv
cpu_datapath.sv
lc3b_cpu.sv
lc3b_cpu_props.sv
tb_lc3b_cpu.sv

// ==== Bender.yml ====
package:
  name: lc3b_cpu

sources:
  - files:
      - lc3b_types.sv
      - lc3b_ctrl_pkg.sv
      - mem_req_if.sv
      - control_rom.sv
      - regfile.sv
      - alu.sv
      - branch_unit.sv
      - dcache_ctrlr.sv
      - cpu_datapath.sv
      - lc3b_cpu.sv
  - target: test
    files:
      - lc3b_cpu_props.sv
      - tb_lc3b_cpu.sv

// ==== tb_lc3b_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_cpu;

	localparam int PROG_LEN = 33;
	localparam int TIMEOUT_NS = (4 + PROG_LEN * 8) * 4;

	logic clk, reset, icache_resp, icache_read, dcache_resp, dcache_read, dcache_write;
	lc3b_types::lc3b_datbus icache_rdata, dcache_rdata, dcache_wdata;
	lc3b_types::lc3b_word icache_addr, dcache_addr, dcache_byte_en;

	logic [15:0] imem [0:63];
	logic [15:0] dmem [0:255];
	logic [15:0] ref_mem [0:255];
	logic [31:0] seed, iseed, dseed;
	logic [1:0] icnt, dcnt;
	logic reset_q;
	logic [2:0] lane;
	logic [15:0] got;
	int err_value, err_other, err_prop;

	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	string exp_name [$];

	lc3b_cpu i_lc3b_cpu (.*);

	bind dcache_ctrlr lc3b_cpu_props i_lc3b_cpu_props (
		.clk(clk),
		.reset(reset),
		.dcache_read(dcache_read),
		.dcache_write(dcache_write),
		.dcache_resp(dcache_resp),
		.dcache_addr(dcache_addr)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	////////////////////////////// encoders
	function automatic logic [15:0] alu_rr(input logic [3:0] op, input int d, s1, s2);
		return {op, d[2:0], s1[2:0], 3'b000, s2[2:0]};
	endfunction

	function automatic logic [15:0] alu_ri(input logic [3:0] op, input int d, s1, imm);
		return {op, d[2:0], s1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic logic [15:0] mem_op(input logic [3:0] op, input int r, b, off);
		return {op, r[2:0], b[2:0], off[5:0]};
	endfunction

	function automatic logic [15:0] line_word_at(input logic [15:0] addr, input int i);
		return dmem[{addr[8:4], i[2:0]}];
	endfunction

	task automatic load_program();
		int r1;
		int r2;
		logic [3:0] add, andi, ldr, str;
		add = lc3b_types::op_add;
		andi = lc3b_types::op_and;
		ldr = lc3b_types::op_ldr;
		str = lc3b_types::op_str;
		seed = xorshift(seed);
		r1 = 10 + seed % 22;
		seed = xorshift(seed);
		r2 = 10 + seed % 22;
		imem = '{default: 16'h0000};
		imem[0] = alu_ri(add, 7, 0, 8);
		imem[1] = alu_rr(add, 7, 7, 7);
		imem[2] = alu_rr(add, 7, 7, 7);
		imem[3] = alu_rr(add, 7, 7, 7);
		imem[4] = alu_ri(add, 1, 0, -3);
		imem[5] = alu_ri(add, 2, 1, 7);
		imem[6] = alu_rr(andi, 3, 1, 2);
		imem[7] = {4'b1001, 3'd4, 3'd3, 6'b111111};
		imem[8] = alu_ri(andi, 5, 4, -2);
		imem[9] = alu_rr(add, 6, 5, 1);
		for (int i = 0; i < 5; i++) begin
			imem[10 + i] = mem_op(str, 2 + i, 7, i);
		end
		// load followed by its use.
		imem[15] = mem_op(ldr, 1, 7, r1);
		imem[16] = alu_rr(add, 2, 1, 1);
		imem[17] = mem_op(str, 2, 7, 5);
		imem[18] = mem_op(ldr, 3, 7, r2);
		imem[19] = mem_op(str, 3, 7, 6);
		imem[20] = alu_ri(andi, 4, 4, 0);
		imem[21] = {4'b0000, 3'b010, 9'd1};
		imem[22] = mem_op(str, 1, 7, 7);
		imem[23] = {4'b0000, 3'b101, 9'd1};
		imem[24] = mem_op(str, 4, 7, 7);
		imem[25] = alu_ri(add, 5, 0, 15);
		imem[26] = alu_rr(add, 5, 5, 5);
		imem[27] = alu_rr(add, 5, 5, 5);
		imem[28] = {4'b1100, 3'b000, 3'd5, 6'b000000};
		imem[29] = mem_op(str, 1, 7, 8);
		imem[30] = alu_ri(add, 6, 6, 1);
		imem[31] = mem_op(str, 6, 7, 9);
		imem[32] = {4'b0000, 3'b111, 9'h1ff};
	endtask

	////////////////////////////// reference model
	function void run_reference();
		logic [15:0] r [8];
		logic [15:0] pc, ir, npc, val, addr;
		logic [2:0] cc;
		int steps;
		r = '{default: 16'h0000};
		pc = 16'h0000;
		cc = 3'b010;
		for (steps = 0; steps < 200; steps++) begin
			ir = imem[pc[6:1]];
			npc = pc + 16'd2;
			val = 16'h0000;
			case (ir[15:12])
				4'b0001, 4'b0101: begin
					val = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
					val = (ir[15:12] == 4'b0001) ? r[ir[8:6]] + val : r[ir[8:6]] & val;
				end
				4'b1001: val = ~r[ir[8:6]];
				4'b0110: val = ref_mem[8'(({r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0}}) >> 1)];
				4'b0111: begin
					addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
					ref_mem[addr[8:1]] = r[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(r[ir[11:9]]);
					exp_name.push_back($sformatf("store at pc %h", pc));
				end
				4'b1100: npc = r[ir[8:6]];
				default: begin
					if ((ir[11:9] & cc) != 3'b000) begin
						npc = npc + {{6{ir[8]}}, ir[8:0], 1'b0};
					end
				end
			endcase
			if (ir[15:12] inside {4'b0001, 4'b0101, 4'b1001, 4'b0110}) begin
				r[ir[11:9]] = val;
				cc = val[15] ? 3'b100 : ((val == 16'h0000) ? 3'b010 : 3'b001);
			end
			// a branch to itself ends the program.
			if (npc == pc) begin
				break;
			end
			pc = npc;
		end
	endfunction

	////////////////////////////// cache models
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			icache_rdata[i * 16 +: 16] = imem[{icache_addr[6:4], 3'(i)}];
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			icache_resp <= 1'b0;
			icnt <= 2'd0;
		end else if (icache_read && icnt == 2'd0) begin
			icache_resp <= 1'b1;
			iseed = xorshift(iseed);
			icnt <= iseed[1:0];
		end else begin
			icache_resp <= 1'b0;
			if (icache_read) begin
				icnt <= icnt - 2'd1;
			end
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			dcache_resp <= 1'b0;
			dcnt <= 2'd0;
		end else if (dcache_resp) begin
			dcache_resp <= 1'b0;
			for (int i = 0; i < 8; i++) begin
				if (dcache_write && dcache_byte_en[2 * i +: 2] == 2'b11) begin
					dmem[{dcache_addr[8:4], 3'(i)}] <= dcache_wdata[i * 16 +: 16];
				end
			end
		end else if (dcache_read || dcache_write) begin
			if (dcnt == 2'd0) begin
				dcache_resp <= 1'b1;
				for (int i = 0; i < 8; i++) begin
					dcache_rdata[i * 16 +: 16] <= line_word_at(dcache_addr, i);
				end
				dseed = xorshift(dseed);
				dcnt <= dseed[1:0];
			end else begin
				dcnt <= dcnt - 2'd1;
			end
		end
	end

	////////////////////////////// comparator
	always @(posedge clk) begin
		reset_q <= reset;
		if (reset && reset_q) begin
			assert (!dcache_read && !dcache_write) else begin
				err_other++;
				$display("dcache strobe was high during reset");
			end
		end
		// a waiting data request holds the fetch side off.
		if (!reset && (dcache_read || dcache_write) && !dcache_resp) begin
			assert (!icache_read) else begin
				err_other++;
				$display("icache_read was high while a dcache request was waiting");
			end
		end
		if (!reset && dcache_resp && dcache_write) begin
			if (exp_addr.size() == 0) begin
				err_other++;
				$display("a store to %h came after the last expected store", dcache_addr);
			end else begin
				lane = dcache_addr[3:1];
				got = dcache_wdata[lane * 16 +: 16];
				assert (dcache_addr == exp_addr[0]) else begin
					err_value++;
					$display("error %s addr: expected %h, actual %h",
						exp_name[0], exp_addr[0], dcache_addr);
				end
				assert (got == exp_data[0]) else begin
					err_value++;
					$display("error %s data: expected %h, actual %h",
						exp_name[0], exp_data[0], got);
				end
				assert (dcache_byte_en == (16'h0003 << (2 * exp_addr[0][3:1]))) else begin
					err_value++;
					$display("error %s byte_en: expected %h, actual %h", exp_name[0],
						16'h0003 << (2 * exp_addr[0][3:1]), dcache_byte_en);
				end
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				void'(exp_name.pop_front());
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		reset_q = 1'b0;
		icache_resp = 1'b0;
		dcache_resp = 1'b0;
		dcache_rdata = '0;
		icnt = 2'd0;
		dcnt = 2'd0;
		err_value = 0;
		err_other = 0;
		err_prop = 0;
		seed = 32'h3501_948b;
		for (int i = 0; i < 256; i++) begin
			seed = xorshift(seed);
			dmem[i] = seed[15:0];
			ref_mem[i] = seed[15:0];
		end
		load_program();
		iseed = xorshift(seed);
		dseed = xorshift(iseed);
		run_reference();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		wait (exp_addr.size() == 0);
		// the core spins in its last branch while late stores are still checked.
		repeat (20) @(posedge clk);
		err_prop = i_lc3b_cpu.i_dcache_ctrlr.i_lc3b_cpu_props.fail_count;
		$display("value errors: %0d, other errors: %0d, assertion errors: %0d",
			err_value, err_other, err_prop);
		if (err_value + err_other + err_prop == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the core did not finish its stores in time");
		$display("*** FAILED ***");
		$finish;
	end

endmodule : tb_lc3b_cpu

`default_nettype wire

// ==== lc3b_cpu_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3b_cpu_props (
	input logic clk,
	input logic reset,
	input logic dcache_read,
	input logic dcache_write,
	input logic dcache_resp,
	input lc3b_types::lc3b_word dcache_addr
);

	// number of failed checks.
	int fail_count = 0;

	// one transaction type at a time.
	read_write_exclusive: assert property (@(posedge clk) !(dcache_read && dcache_write))
		else begin
			fail_count++;
			$error("dcache read and write are high together");
		end

	// the first reset edge clears the controller, so check from the second one on.
	quiet_in_reset: assert property (@(posedge clk)
		(reset ##1 reset) |-> (!dcache_read && !dcache_write))
		else begin
			fail_count++;
			$error("dcache strobe is high during reset");
		end

	request_held: assert property (@(posedge clk) disable iff (reset)
		((dcache_read || dcache_write) && !dcache_resp)
		|=> ($stable(dcache_addr) && $stable(dcache_read) && $stable(dcache_write)))
		else begin
			fail_count++;
			$error("dcache request changed before the response");
		end

endmodule : lc3b_cpu_props

`default_nettype wire

// ==== lc3b_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3b_cpu (
	input logic clk,
	input logic reset,
	input logic icache_resp,
	input lc3b_types::lc3b_datbus icache_rdata,
	output lc3b_types::lc3b_word icache_addr,
	output logic icache_read,
	input logic dcache_resp,
	input lc3b_types::lc3b_datbus dcache_rdata,
	output lc3b_types::lc3b_word dcache_addr,
	output lc3b_types::lc3b_datbus dcache_wdata,
	output lc3b_types::lc3b_word dcache_byte_en,
	output logic dcache_read,
	output logic dcache_write
);

	mem_req_if mem_bus ();
	logic stall;

	cpu_datapath i_cpu_datapath (
		.clk,
		.reset,
		.stall,
		.icache_resp,
		.icache_rdata,
		.icache_addr,
		.icache_read,
		.mem(mem_bus.core)
	);

	dcache_ctrlr i_dcache_ctrlr (
		.clk,
		.reset,
		.mem(mem_bus.ctrl),
		.stall,
		.dcache_resp,
		.dcache_rdata,
		.dcache_addr,
		.dcache_read,
		.dcache_write,
		.dcache_wdata,
		.dcache_byte_en
	);

endmodule : lc3b_cpu

`default_nettype wire

// ==== cpu_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic icache_resp,
	input lc3b_types::lc3b_datbus icache_rdata,
	output lc3b_types::lc3b_word icache_addr,
	output logic icache_read,
	mem_req_if.core mem
);

	lc3b_types::lc3b_word pc, pc_plus2, pc_next, fetch_word;
	logic [$clog2(lc3b_types::LINE_WORDS)-1:0] fetch_lane;

	lc3b_types::lc3b_word ifid_next_pc, ifid_instr;

	lc3b_ctrl_pkg::lc3b_ctrl_word id_ctrl;
	lc3b_types::lc3b_reg id_src1, id_src2, id_dest;
	lc3b_types::lc3b_word id_reg_a, id_reg_b;
	logic raw_ex, raw_me, cc_wait, hazard;

	lc3b_ctrl_pkg::lc3b_ctrl_word idex_ctrl;
	lc3b_types::lc3b_reg idex_dest;
	lc3b_types::lc3b_word idex_next_pc, idex_reg_a, idex_reg_b;

	lc3b_types::lc3b_word alu_b, alu_out, br_target;
	logic br_taken;

	lc3b_ctrl_pkg::lc3b_ctrl_word exme_ctrl;
	lc3b_types::lc3b_reg exme_dest;
	lc3b_types::lc3b_word exme_result, exme_store, me_data;

	lc3b_ctrl_pkg::lc3b_ctrl_word mewb_ctrl;
	lc3b_types::lc3b_reg mewb_dest;
	lc3b_types::lc3b_word mewb_data;
	lc3b_types::lc3b_nzp cc, gen_cc;

	////////////////////////////// IF
	assign pc_plus2 = pc + 16'd2;
	assign pc_next = br_taken ? br_target : pc_plus2;
	assign icache_addr = pc;
	assign icache_read = ~stall;
	assign fetch_lane = pc[3:1];
	assign fetch_word = lc3b_types::lc3b_word'(icache_rdata >> {fetch_lane, 4'h0});

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= lc3b_types::LC3B_RESET_PC;
			ifid_instr <= lc3b_types::LC3B_NOP;
		end else if (!stall) begin
			if (br_taken) begin
				pc <= pc_next;
				ifid_instr <= lc3b_types::LC3B_NOP;
			end else if (!hazard) begin
				if (icache_resp) begin
					pc <= pc_next;
				end
				// no response yet, so a bubble moves on.
				ifid_instr <= icache_resp ? fetch_word : lc3b_types::LC3B_NOP;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !hazard) begin
			ifid_next_pc <= pc_plus2;
		end
	end

	////////////////////////////// ID
	control_rom i_control_rom (
		.instr(ifid_instr),
		.ctrl(id_ctrl),
		.src1(id_src1),
		.src2(id_src2),
		.dest(id_dest)
	);

	regfile i_regfile (
		.clk,
		.reset,
		.load(mewb_ctrl.load_regfile),
		.in(mewb_data),
		.src_a(id_src1),
		.src_b(id_src2),
		.dest(mewb_dest),
		.reg_a(id_reg_a),
		.reg_b(id_reg_b)
	);

	// WB needs no check, the regfile passes its write through.
	assign raw_ex = idex_ctrl.load_regfile
		&& ((id_ctrl.uses_src1 && id_src1 == idex_dest)
		|| (id_ctrl.uses_src2 && id_src2 == idex_dest));
	assign raw_me = exme_ctrl.load_regfile
		&& ((id_ctrl.uses_src1 && id_src1 == exme_dest)
		|| (id_ctrl.uses_src2 && id_src2 == exme_dest));
	assign cc_wait = (id_ctrl.opcode == lc3b_types::op_br) && (id_dest != 3'b000)
		&& (idex_ctrl.load_cc || exme_ctrl.load_cc);
	assign hazard = raw_ex | raw_me | cc_wait;

	always_ff @(posedge clk) begin
		if (reset) begin
			idex_ctrl <= lc3b_ctrl_pkg::CTRL_NOP;
			idex_dest <= 3'b000;
		end else if (!stall) begin
			if (br_taken || hazard) begin
				idex_ctrl <= lc3b_ctrl_pkg::CTRL_NOP;
				idex_dest <= 3'b000;
			end else begin
				idex_ctrl <= id_ctrl;
				idex_dest <= id_dest;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			idex_next_pc <= ifid_next_pc;
			idex_reg_a <= id_reg_a;
			idex_reg_b <= id_reg_b;
		end
	end

	////////////////////////////// EX
	assign alu_b = (idex_ctrl.alub_sel == lc3b_ctrl_pkg::alub_imm) ? idex_ctrl.imm : idex_reg_b;

	alu i_alu (
		.aluop(idex_ctrl.aluop),
		.a(idex_reg_a),
		.b(alu_b),
		.f(alu_out)
	);

	branch_unit i_branch_unit (
		.opcode(idex_ctrl.opcode),
		.nzp_field(idex_dest),
		.cc,
		.next_pc(idex_next_pc),
		.offset9(idex_ctrl.imm),
		.base(idex_reg_a),
		.target(br_target),
		.taken(br_taken)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			exme_ctrl <= lc3b_ctrl_pkg::CTRL_NOP;
			exme_dest <= 3'b000;
		end else if (!stall) begin
			exme_ctrl <= idex_ctrl;
			exme_dest <= idex_dest;
		end
	end

	// alu result doubles as the memory address.
	always_ff @(posedge clk) begin
		if (!stall) begin
			exme_result <= alu_out;
			exme_store <= idex_reg_b;
		end
	end

	////////////////////////////// ME
	assign mem.addr = exme_result;
	assign mem.wdata = exme_store;
	assign mem.read = (exme_ctrl.memop == lc3b_ctrl_pkg::mem_read);
	assign mem.write = (exme_ctrl.memop == lc3b_ctrl_pkg::mem_write);
	assign me_data = (exme_ctrl.wb_sel == lc3b_ctrl_pkg::wb_mem) ? mem.rdata : exme_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			mewb_ctrl <= lc3b_ctrl_pkg::CTRL_NOP;
			mewb_dest <= 3'b000;
		end else if (!stall) begin
			mewb_ctrl <= exme_ctrl;
			mewb_dest <= exme_dest;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			mewb_data <= me_data;
		end
	end

	////////////////////////////// WB
	assign gen_cc[2] = mewb_data[15];
	assign gen_cc[1] = (mewb_data == 16'h0000);
	assign gen_cc[0] = ~mewb_data[15] && (mewb_data != 16'h0000);

	always_ff @(posedge clk) begin
		if (reset) begin
			cc <= 3'b010;
		end else if (mewb_ctrl.load_cc) begin
			cc <= gen_cc;
		end
	end

endmodule : cpu_datapath

`default_nettype wire

// ==== dcache_ctrlr.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrlr (
	input logic clk,
	input logic reset,
	mem_req_if.ctrl mem,
	output logic stall,
	input logic dcache_resp,
	input lc3b_types::lc3b_datbus dcache_rdata,
	output lc3b_types::lc3b_word dcache_addr,
	output logic dcache_read,
	output logic dcache_write,
	output lc3b_types::lc3b_datbus dcache_wdata,
	output lc3b_types::lc3b_word dcache_byte_en
);

	typedef enum logic {
		dc_idle,
		dc_busy
	} dc_state_t;

	dc_state_t state;
	logic req;
	logic [$clog2(lc3b_types::LINE_WORDS)-1:0] lane;

	assign req = mem.read | mem.write;
	assign lane = mem.addr[3:1];

	// a request seen in idle is issued to the cache the next cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dc_idle;
		end else begin
			case (state)
				dc_idle: begin
					if (req) begin
						state <= dc_busy;
					end
				end
				default: begin
					if (dcache_resp) begin
						state <= dc_idle;
					end
				end
			endcase
		end
	end

	assign dcache_read = (state == dc_busy) & mem.read;
	assign dcache_write = (state == dc_busy) & mem.write;
	assign dcache_addr = mem.addr;

	// word lanes.
	assign dcache_wdata = lc3b_types::lc3b_datbus'(mem.wdata) << {lane, 4'h0};
	assign dcache_byte_en = 16'h0003 << {lane, 1'b0};
	assign mem.rdata = lc3b_types::lc3b_word'(dcache_rdata >> {lane, 4'h0});

	assign mem.done = (state == dc_busy) & dcache_resp;
	assign stall = req & ~mem.done;

endmodule : dcache_ctrlr

`default_nettype wire

// ==== branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
	input lc3b_types::lc3b_opcode opcode,
	input lc3b_types::lc3b_nzp nzp_field,
	input lc3b_types::lc3b_nzp cc,
	input lc3b_types::lc3b_word next_pc,
	input lc3b_types::lc3b_word offset9,
	input lc3b_types::lc3b_word base,
	output lc3b_types::lc3b_word target,
	output logic taken
);

	logic is_br;
	logic is_jmp;
	lc3b_types::lc3b_word br_target;

	assign is_br = (opcode == lc3b_types::op_br);
	assign is_jmp = (opcode == lc3b_types::op_jmp);

	// pc-relative offset counts words.
	assign br_target = next_pc + {offset9[14:0], 1'b0};

	// an empty nzp field never matches, so bubbles fall through.
	assign taken = (is_br && |(nzp_field & cc)) || is_jmp;
	assign target = is_jmp ? base : br_target;

endmodule : branch_unit

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input lc3b_ctrl_pkg::lc3b_aluop aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);

	// base plus offset for LDR and STR goes through alu_add.
	always_comb begin
		case (aluop)
			lc3b_ctrl_pkg::alu_add: begin
				f = a + b;
			end
			lc3b_ctrl_pkg::alu_and: begin
				f = a & b;
			end
			lc3b_ctrl_pkg::alu_not: begin
				f = ~a;
			end
			default: begin
				f = a;
			end
		endcase
	end

endmodule : alu

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	input lc3b_types::lc3b_reg dest,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);

	lc3b_types::lc3b_word data [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				data[i] <= '0;
			end
		end else if (load) begin
			data[dest] <= in;
		end
	end

	// a value written this cycle is seen by the reader.
	assign reg_a = (load && src_a == dest) ? in : data[src_a];
	assign reg_b = (load && src_b == dest) ? in : data[src_b];

endmodule : regfile

`default_nettype wire

// ==== control_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_rom (
	input lc3b_types::lc3b_word instr,
	output lc3b_ctrl_pkg::lc3b_ctrl_word ctrl,
	output lc3b_types::lc3b_reg src1,
	output lc3b_types::lc3b_reg src2,
	output lc3b_types::lc3b_reg dest
);

	lc3b_types::lc3b_opcode opcode;

	assign opcode = lc3b_types::lc3b_opcode'(instr[15:12]);

	assign src1 = instr[8:6];
	// STR reads its data register from the dest field.
	assign src2 = (opcode == lc3b_types::op_str) ? instr[11:9] : instr[2:0];
	assign dest = instr[11:9];

	always_comb begin
		ctrl = lc3b_ctrl_pkg::CTRL_NOP;
		ctrl.opcode = opcode;
		case (opcode)
			lc3b_types::op_add, lc3b_types::op_and: begin
				ctrl.aluop = (opcode == lc3b_types::op_add) ? lc3b_ctrl_pkg::alu_add
					: lc3b_ctrl_pkg::alu_and;
				ctrl.alub_sel = instr[5] ? lc3b_ctrl_pkg::alub_imm : lc3b_ctrl_pkg::alub_reg;
				ctrl.imm = {{11{instr[4]}}, instr[4:0]};
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.uses_src1 = 1'b1;
				ctrl.uses_src2 = ~instr[5];
			end
			lc3b_types::op_not: begin
				ctrl.aluop = lc3b_ctrl_pkg::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.uses_src1 = 1'b1;
			end
			lc3b_types::op_br: begin
				ctrl.imm = {{7{instr[8]}}, instr[8:0]};
			end
			lc3b_types::op_jmp: begin
				ctrl.uses_src1 = 1'b1;
			end
			lc3b_types::op_ldr, lc3b_types::op_str: begin
				ctrl.aluop = lc3b_ctrl_pkg::alu_add;
				ctrl.alub_sel = lc3b_ctrl_pkg::alub_imm;
				// offset6 is a word offset.
				ctrl.imm = {{9{instr[5]}}, instr[5:0], 1'b0};
				ctrl.uses_src1 = 1'b1;
				if (opcode == lc3b_types::op_ldr) begin
					ctrl.memop = lc3b_ctrl_pkg::mem_read;
					ctrl.wb_sel = lc3b_ctrl_pkg::wb_mem;
					ctrl.load_regfile = 1'b1;
					ctrl.load_cc = 1'b1;
				end else begin
					ctrl.memop = lc3b_ctrl_pkg::mem_write;
					ctrl.uses_src2 = 1'b1;
				end
			end
			default: begin
				ctrl = lc3b_ctrl_pkg::CTRL_NOP;
			end
		endcase
	end

endmodule : control_rom

`default_nettype wire

// ==== mem_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mem_req_if;

	// request from the ME stage.
	lc3b_types::lc3b_word addr;
	lc3b_types::lc3b_word wdata;
	logic read;
	logic write;

	// word picked out of the returned line.
	lc3b_types::lc3b_word rdata;
	logic done;

	modport core (
		output addr, wdata, read, write,
		input rdata, done
	);

	modport ctrl (
		input addr, wdata, read, write,
		output rdata, done
	);

endinterface : mem_req_if

`default_nettype wire

// ==== lc3b_ctrl_pkg.sv ====
`default_nettype none

package lc3b_ctrl_pkg;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	typedef enum logic {
		alub_reg,
		alub_imm
	} lc3b_alub_sel;

	typedef enum logic [1:0] {
		mem_none,
		mem_read,
		mem_write
	} lc3b_memop;

	typedef enum logic {
		wb_alu,
		wb_mem
	} lc3b_wb_sel;

	typedef struct packed {
		lc3b_types::lc3b_opcode opcode;
		lc3b_aluop aluop;
		lc3b_alub_sel alub_sel;
		lc3b_memop memop;
		lc3b_wb_sel wb_sel;
		logic load_regfile;
		logic load_cc;
		logic uses_src1;
		logic uses_src2;
		lc3b_types::lc3b_word imm;
	} lc3b_ctrl_word;

	// control word of a bubble.
	localparam lc3b_ctrl_word CTRL_NOP = '{
		opcode: lc3b_types::op_br,
		aluop: alu_pass,
		alub_sel: alub_reg,
		memop: mem_none,
		wb_sel: wb_alu,
		load_regfile: 1'b0,
		load_cc: 1'b0,
		uses_src1: 1'b0,
		uses_src2: 1'b0,
		imm: 16'h0000
	};

endpackage : lc3b_ctrl_pkg

`default_nettype wire

// ==== lc3b_types.sv ====
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [127:0] lc3b_datbus;

	// n, z, p from msb to lsb.
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	localparam lc3b_word LC3B_RESET_PC = 16'h0000;

	// BR with an empty nzp field, used as the pipeline bubble.
	localparam lc3b_word LC3B_NOP = 16'h0000;

	localparam int LINE_WORDS = 8;

endpackage : lc3b_types

`default_nettype wire
